// File: design/blkdev_params.svh
`ifndef BLKDEV_PARAMS_SVH
`define BLKDEV_PARAMS_SVH

// bus data word width
`define BLK_ARCHBITSZ 16
// one select per byte lane
`define BLK_SELBITSZ (`BLK_ARCHBITSZ / 8)
// word address width on the device bus
`define BLK_ADDRBITSZ 15

// block geometry
`define BLK_WORDS 16
`define BLK_WORDBITSZ 4
`define BLK_NBLOCKS 8
`define BLK_BLKBITSZ 3

// block loaded by the boot loader
`define BLK_BOOTBLOCK 0
// cache window sits right above the command registers
`define BLK_CACHE_BASE `BLK_WORDS

`endif

// File: design/blkdev_pkg.sv
`default_nettype none

package blkdev_pkg;

	// bus operation codes with bit 0 set on writes
	typedef enum logic [1:0] {
		PI_NOOP = 2'b00,
		PI_WROP = 2'b01,
		PI_RDOP = 2'b10,
		PI_RWOP = 2'b11
	} pi_op_e;

	// command register addresses
	typedef enum logic [1:0] {
		CMD_RESET = 2'd0,
		CMD_SWAP  = 2'd1,
		CMD_READ  = 2'd2,
		CMD_WRITE = 2'd3
	} blk_cmd_e;

	// status codes returned by the status register
	typedef enum logic [1:0] {
		STATUS_POWEROFF = 2'd0,
		STATUS_READY    = 2'd1,
		STATUS_BUSY     = 2'd2,
		STATUS_ERROR    = 2'd3
	} blk_status_e;

	// boot sequencer states
	typedef enum logic [2:0] {
		BOOT_STATUS = 3'd0,
		BOOT_RESET  = 3'd1,
		BOOT_READ   = 3'd2,
		BOOT_SWAP   = 3'd3,
		BOOT_DONE   = 3'd4
	} boot_state_e;

endpackage

`default_nettype wire

// File: design/boot_loader.sv
`timescale 1ns/10ps
`default_nettype none

`include "blkdev_params.svh"

module boot_loader #(
	parameter int BOOTBLOCK = `BLK_BOOTBLOCK
) (
	input  wire                          clk_i,
	input  wire                          rst_i,
	// external master side
	input  blkdev_pkg::pi_op_e           m_op_i,
	input  wire [`BLK_ADDRBITSZ-1:0]     m_addr_i,
	input  wire [`BLK_ARCHBITSZ-1:0]     m_data_i,
	input  wire [`BLK_SELBITSZ-1:0]      m_sel_i,
	output logic [`BLK_ARCHBITSZ-1:0]    m_data_o,
	output logic                         m_rdy_o,
	// device side
	output blkdev_pkg::pi_op_e           s_op_o,
	output logic [`BLK_ADDRBITSZ-1:0]    s_addr_o,
	output logic [`BLK_ARCHBITSZ-1:0]    s_data_o,
	output logic [`BLK_SELBITSZ-1:0]     s_sel_o,
	input  wire [`BLK_ARCHBITSZ-1:0]     s_data_i,
	input  wire                          s_rdy_i
);

	import blkdev_pkg::*;

	boot_state_e state;
	// state to enter once status reads ready
	boot_state_e next_state;
	// status read data is trusted only from the second status cycle
	logic        stat_vld;
	logic        done;

	assign done = (state == BOOT_DONE);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state      <= BOOT_STATUS;
			next_state <= BOOT_RESET;
			stat_vld   <= 1'b0;
		end else begin
			stat_vld <= (state == BOOT_STATUS);
			case (state)
				BOOT_STATUS: begin
					// wait for the device to report ready
					if (s_rdy_i && stat_vld &&
						s_data_i == `BLK_ARCHBITSZ'(STATUS_READY)) begin
						state <= next_state;
					end
				end
				BOOT_RESET: begin
					if (s_rdy_i) begin
						state      <= BOOT_STATUS;
						next_state <= BOOT_READ;
					end
				end
				BOOT_READ: begin
					// block transfer runs in the background so poll again
					if (s_rdy_i) begin
						state      <= BOOT_STATUS;
						next_state <= BOOT_SWAP;
					end
				end
				BOOT_SWAP: begin
					if (s_rdy_i) begin
						state <= BOOT_DONE;
					end
				end
				default: begin
					// hold done until reset
					state <= BOOT_DONE;
				end
			endcase
		end
	end

	always_comb begin
		// pass-through once booted
		s_op_o   = m_op_i;
		s_addr_o = m_addr_i;
		s_data_o = m_data_i;
		s_sel_o  = m_sel_i;
		m_data_o = s_data_i;
		m_rdy_o  = s_rdy_i;
		if (!done) begin
			// master is stalled with zero data during boot
			m_data_o = '0;
			m_rdy_o  = 1'b0;
			// every boot command is a full word read-write
			s_op_o   = PI_RWOP;
			s_sel_o  = {`BLK_SELBITSZ{1'b1}};
			s_data_o = '0;
			case (state)
				BOOT_RESET: begin
					s_addr_o = `BLK_ADDRBITSZ'(CMD_RESET);
					s_data_o = `BLK_ARCHBITSZ'(1);
				end
				BOOT_READ: begin
					s_addr_o = `BLK_ADDRBITSZ'(CMD_READ);
					s_data_o = `BLK_ARCHBITSZ'(BOOTBLOCK);
				end
				BOOT_SWAP: begin
					s_addr_o = `BLK_ADDRBITSZ'(CMD_SWAP);
				end
				default: begin
					// status read shares address 0 with reset
					s_addr_o = `BLK_ADDRBITSZ'(CMD_RESET);
				end
			endcase
		end
	end

	// master ready only answers a pending master request after boot
	a_no_rdy_before_done: assert property (@(posedge clk_i) disable iff (rst_i)
		m_rdy_o |-> done && (m_op_i != PI_NOOP));

endmodule

`default_nettype wire

// File: design/blkdev_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "blkdev_params.svh"

module blkdev_ctrl (
	input  wire                                          clk_i,
	input  wire                                          rst_i,
	// device bus
	input  blkdev_pkg::pi_op_e                           op_i,
	input  wire [`BLK_ADDRBITSZ-1:0]                     addr_i,
	input  wire [`BLK_ARCHBITSZ-1:0]                     data_i,
	input  wire [`BLK_SELBITSZ-1:0]                      sel_i,
	output logic [`BLK_ARCHBITSZ-1:0]                    data_o,
	output logic                                         rdy_o,
	// cache front bank
	input  wire [`BLK_ARCHBITSZ-1:0]                     cache_rdata_i,
	output logic                                         cache_we_o,
	output logic [`BLK_SELBITSZ-1:0]                     cache_wsel_o,
	output logic [`BLK_WORDBITSZ-1:0]                    cache_addr_o,
	output logic [`BLK_ARCHBITSZ-1:0]                    cache_wdata_o,
	// cache back bank
	input  wire [`BLK_ARCHBITSZ-1:0]                     eng_rdata_i,
	output logic                                         eng_we_o,
	output logic [`BLK_WORDBITSZ-1:0]                    eng_addr_o,
	output logic [`BLK_ARCHBITSZ-1:0]                    eng_wdata_o,
	output logic                                         swap_o,
	// backing store
	input  wire [`BLK_ARCHBITSZ-1:0]                     store_rdata_i,
	input  wire                                          fill_busy_i,
	output logic [`BLK_BLKBITSZ+`BLK_WORDBITSZ-1:0]      store_addr_o,
	output logic                                         store_we_o,
	output logic [`BLK_ARCHBITSZ-1:0]                    store_wdata_o
);

	import blkdev_pkg::*;

	logic                       req;
	logic                       wr_op;
	logic                       is_cmd;
	logic                       is_status;
	logic                       is_cache;
	logic [`BLK_ADDRBITSZ-1:0]  cache_off;
	blk_cmd_e                   cmd;
	blk_status_e                status;
	logic                       busy;
	logic                       cmd_acc;
	logic                       xfer_start;
	logic                       ctrl_rst;
	// transfer engine state
	logic                       xfer_busy;
	logic                       xfer_wr;
	logic [`BLK_BLKBITSZ-1:0]   xfer_blk;
	logic [`BLK_WORDBITSZ-1:0]  xfer_cnt;

	assign req   = (op_i != PI_NOOP);
	// op bit 0 marks a write
	assign wr_op = (op_i == PI_WROP) || (op_i == PI_RWOP);

	// address decode
	assign cmd       = blk_cmd_e'(addr_i[1:0]);
	assign is_cmd    = (addr_i[`BLK_ADDRBITSZ-1:2] == '0);
	assign is_status = is_cmd && (cmd == CMD_RESET);
	// offset wraps below the base so one compare covers the window
	assign cache_off = addr_i - `BLK_ADDRBITSZ'(`BLK_CACHE_BASE);
	assign is_cache  = (cache_off < `BLK_ADDRBITSZ'(`BLK_WORDS));

	// fill and transfers both report busy
	assign busy   = xfer_busy || fill_busy_i;
	assign status = busy ? STATUS_BUSY : STATUS_READY;

	// status always answers while everything else stalls on busy
	assign rdy_o = req && (is_status || !busy);

	always_comb begin
		data_o = '0;
		if (is_status) begin
			data_o = `BLK_ARCHBITSZ'(status);
		end else if (is_cache) begin
			data_o = cache_rdata_i;
		end
	end

	// commands are read-write accesses only
	assign cmd_acc    = rdy_o && is_cmd && (op_i == PI_RWOP);
	assign ctrl_rst   = cmd_acc && (cmd == CMD_RESET) && (data_i == `BLK_ARCHBITSZ'(1));
	assign swap_o     = cmd_acc && (cmd == CMD_SWAP);
	assign xfer_start = cmd_acc && ((cmd == CMD_READ) || (cmd == CMD_WRITE));

	// front bank access
	assign cache_we_o    = rdy_o && is_cache && wr_op;
	assign cache_wsel_o  = sel_i;
	assign cache_addr_o  = cache_off[`BLK_WORDBITSZ-1:0];
	assign cache_wdata_o = data_i;

	always_ff @(posedge clk_i) begin
		if (rst_i || ctrl_rst) begin
			xfer_busy <= 1'b0;
			xfer_cnt  <= '0;
		end else if (xfer_start) begin
			xfer_busy <= 1'b1;
			xfer_cnt  <= '0;
		end else if (xfer_busy) begin
			// one word per cycle
			xfer_cnt <= xfer_cnt + 1'b1;
			if (xfer_cnt == `BLK_WORDBITSZ'(`BLK_WORDS - 1)) begin
				xfer_busy <= 1'b0;
			end
		end
	end

	// block index and direction latched with the command
	always_ff @(posedge clk_i) begin
		if (xfer_start) begin
			xfer_blk <= data_i[`BLK_BLKBITSZ-1:0];
			xfer_wr  <= (cmd == CMD_WRITE);
		end
	end

	// read copies store to back bank and write copies back bank to store
	assign store_addr_o  = {xfer_blk, xfer_cnt};
	assign store_we_o    = xfer_busy && xfer_wr;
	assign store_wdata_o = eng_rdata_i;
	assign eng_addr_o    = xfer_cnt;
	assign eng_we_o      = xfer_busy && !xfer_wr;
	assign eng_wdata_o   = store_rdata_i;

	// a swap would move the bank under the running engine or the fill
	a_no_swap_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		swap_o |-> !xfer_busy && !fill_busy_i);

endmodule

`default_nettype wire

// File: design/blkdev_cache.sv
`timescale 1ns/10ps
`default_nettype none

`include "blkdev_params.svh"

module blkdev_cache (
	input  wire                          clk_i,
	input  wire                          rst_i,
	input  wire                          swap_i,
	// front bank port
	input  wire                          bus_we_i,
	input  wire [`BLK_SELBITSZ-1:0]      bus_sel_i,
	input  wire [`BLK_WORDBITSZ-1:0]     bus_addr_i,
	input  wire [`BLK_ARCHBITSZ-1:0]     bus_wdata_i,
	output logic [`BLK_ARCHBITSZ-1:0]    bus_rdata_o,
	// back bank port
	input  wire                          eng_we_i,
	input  wire [`BLK_WORDBITSZ-1:0]     eng_addr_i,
	input  wire [`BLK_ARCHBITSZ-1:0]     eng_wdata_i,
	output logic [`BLK_ARCHBITSZ-1:0]    eng_rdata_o
);

	logic [`BLK_ARCHBITSZ-1:0] mem [0:1][0:`BLK_WORDS-1];
	// index of the bank seen by the bus
	logic                      front;
	logic                      back;

	assign back = ~front;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			front <= 1'b0;
		end else if (swap_i) begin
			front <= ~front;
		end
	end

	always_ff @(posedge clk_i) begin
		// byte lanes written one by one
		if (bus_we_i) begin
			for (int i = 0; i < `BLK_SELBITSZ; i++) begin
				if (bus_sel_i[i]) begin
					mem[front][bus_addr_i][8*i +: 8] <= bus_wdata_i[8*i +: 8];
				end
			end
		end
		// engine always writes full words
		if (eng_we_i) begin
			mem[back][eng_addr_i] <= eng_wdata_i;
		end
	end

	// combinational reads on both banks
	assign bus_rdata_o = mem[front][bus_addr_i];
	assign eng_rdata_o = mem[back][eng_addr_i];

endmodule

`default_nettype wire

// File: design/blk_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "blkdev_params.svh"

module blk_store (
	input  wire                                      clk_i,
	input  wire                                      rst_i,
	input  wire [`BLK_BLKBITSZ+`BLK_WORDBITSZ-1:0]   addr_i,
	input  wire                                      we_i,
	input  wire [`BLK_ARCHBITSZ-1:0]                 wdata_i,
	output logic [`BLK_ARCHBITSZ-1:0]                rdata_o,
	output logic                                     fill_busy_o
);

	localparam int ABITS = `BLK_BLKBITSZ + `BLK_WORDBITSZ;
	localparam int HALF  = `BLK_ARCHBITSZ / 2;

	logic [`BLK_ARCHBITSZ-1:0] mem [0:`BLK_NBLOCKS*`BLK_WORDS-1];
	// word being filled with the block in the upper bits
	logic [ABITS-1:0]          fill_cnt;
	logic [`BLK_ARCHBITSZ-1:0] fill_word;

	// block index in the high byte, word index in the low byte
	assign fill_word = {HALF'(fill_cnt[ABITS-1:`BLK_WORDBITSZ]),
		HALF'(fill_cnt[`BLK_WORDBITSZ-1:0])};

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			fill_cnt    <= '0;
			fill_busy_o <= 1'b1;
		end else if (fill_busy_o) begin
			fill_cnt <= fill_cnt + 1'b1;
			// last word of the last block
			if (fill_cnt == ABITS'(`BLK_NBLOCKS * `BLK_WORDS - 1)) begin
				fill_busy_o <= 1'b0;
			end
		end
	end

	// fill owns the write port until done
	always_ff @(posedge clk_i) begin
		if (fill_busy_o) begin
			mem[fill_cnt] <= fill_word;
		end else if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
	end

	assign rdata_o = mem[addr_i];

	// controller must hold off writes while the pattern fill runs
	a_no_write_fill: assert property (@(posedge clk_i) disable iff (rst_i)
		fill_busy_o |-> !we_i);

endmodule

`default_nettype wire

// File: design/blkdev_boot_sys.sv
`timescale 1ns/10ps
`default_nettype none

`include "blkdev_params.svh"

module blkdev_boot_sys (
	input  wire                          clk_i,
	input  wire                          rst_i,
	input  blkdev_pkg::pi_op_e           m_op_i,
	input  wire [`BLK_ADDRBITSZ-1:0]     m_addr_i,
	input  wire [`BLK_ARCHBITSZ-1:0]     m_data_i,
	input  wire [`BLK_SELBITSZ-1:0]      m_sel_i,
	output logic [`BLK_ARCHBITSZ-1:0]    m_data_o,
	output logic                         m_rdy_o
);

	import blkdev_pkg::*;

	// loader to controller bus
	pi_op_e                                  s_op;
	logic [`BLK_ADDRBITSZ-1:0]               s_addr;
	logic [`BLK_ARCHBITSZ-1:0]               s_wdata;
	logic [`BLK_ARCHBITSZ-1:0]               s_rdata;
	logic [`BLK_SELBITSZ-1:0]                s_sel;
	logic                                    s_rdy;
	// cache ports
	logic                                    cache_we;
	logic [`BLK_SELBITSZ-1:0]                cache_wsel;
	logic [`BLK_WORDBITSZ-1:0]               cache_addr;
	logic [`BLK_ARCHBITSZ-1:0]               cache_wdata;
	logic [`BLK_ARCHBITSZ-1:0]               cache_rdata;
	logic                                    eng_we;
	logic [`BLK_WORDBITSZ-1:0]               eng_addr;
	logic [`BLK_ARCHBITSZ-1:0]               eng_wdata;
	logic [`BLK_ARCHBITSZ-1:0]               eng_rdata;
	logic                                    swap;
	// store port
	logic [`BLK_BLKBITSZ+`BLK_WORDBITSZ-1:0] store_addr;
	logic                                    store_we;
	logic [`BLK_ARCHBITSZ-1:0]               store_wdata;
	logic [`BLK_ARCHBITSZ-1:0]               store_rdata;
	logic                                    fill_busy;

	boot_loader #(
		.BOOTBLOCK (`BLK_BOOTBLOCK)
	) u_boot_loader (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.m_op_i   (m_op_i),
		.m_addr_i (m_addr_i),
		.m_data_i (m_data_i),
		.m_sel_i  (m_sel_i),
		.m_data_o (m_data_o),
		.m_rdy_o  (m_rdy_o),
		.s_op_o   (s_op),
		.s_addr_o (s_addr),
		.s_data_o (s_wdata),
		.s_sel_o  (s_sel),
		.s_data_i (s_rdata),
		.s_rdy_i  (s_rdy)
	);

	blkdev_ctrl u_blkdev_ctrl (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.op_i          (s_op),
		.addr_i        (s_addr),
		.data_i        (s_wdata),
		.sel_i         (s_sel),
		.data_o        (s_rdata),
		.rdy_o         (s_rdy),
		.cache_rdata_i (cache_rdata),
		.cache_we_o    (cache_we),
		.cache_wsel_o  (cache_wsel),
		.cache_addr_o  (cache_addr),
		.cache_wdata_o (cache_wdata),
		.eng_rdata_i   (eng_rdata),
		.eng_we_o      (eng_we),
		.eng_addr_o    (eng_addr),
		.eng_wdata_o   (eng_wdata),
		.swap_o        (swap),
		.store_rdata_i (store_rdata),
		.fill_busy_i   (fill_busy),
		.store_addr_o  (store_addr),
		.store_we_o    (store_we),
		.store_wdata_o (store_wdata)
	);

	blkdev_cache u_blkdev_cache (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.swap_i      (swap),
		.bus_we_i    (cache_we),
		.bus_sel_i   (cache_wsel),
		.bus_addr_i  (cache_addr),
		.bus_wdata_i (cache_wdata),
		.bus_rdata_o (cache_rdata),
		.eng_we_i    (eng_we),
		.eng_addr_i  (eng_addr),
		.eng_wdata_i (eng_wdata),
		.eng_rdata_o (eng_rdata)
	);

	blk_store u_blk_store (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.addr_i      (store_addr),
		.we_i        (store_we),
		.wdata_i     (store_wdata),
		.rdata_o     (store_rdata),
		.fill_busy_o (fill_busy)
	);

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_o,
	output logic rst_o
);

	// free running clock with the first rising edge half a period in
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// power-on reset released on a falling edge
	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

`default_nettype wire

// File: tb/blkdev_boot_sys_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "blkdev_params.svh"

module blkdev_boot_sys_tb;

	import blkdev_pkg::*;

	localparam int PERIOD_NS    = 100;
	localparam int RESET_CYCLES = 5;
	// outputs are looked at a quarter period after the falling edge
	localparam int SETTLE_NS    = PERIOD_NS / 4;
	localparam int FILL_CYCLES  = `BLK_NBLOCKS * `BLK_WORDS;
	// reset, read and swap commands plus their status polls
	localparam int BOOT_CYCLES  = 4 * `BLK_WORDS;
	localparam int CASE_CYCLES  = 40;

	// case kinds in the first column
	localparam int K_ACCESS = 0;
	localparam int K_POLL   = 1;
	localparam int K_BOOT   = 2;
	localparam int K_RESET  = 3;
	localparam int K_BLOCK  = 4;

	typedef struct {
		int                          kind;
		pi_op_e                      op;
		logic [`BLK_ADDRBITSZ-1:0]   addr;
		logic [`BLK_ARCHBITSZ-1:0]   data;
		logic [`BLK_SELBITSZ-1:0]    sel;
		logic [`BLK_ARCHBITSZ-1:0]   exp_val;
		logic                        chk;
	} case_t;

	logic                        clk;
	logic                        gen_rst;
	logic                        tb_rst;
	logic                        rst;
	pi_op_e                      m_op;
	logic [`BLK_ADDRBITSZ-1:0]   m_addr;
	logic [`BLK_ARCHBITSZ-1:0]   m_data;
	logic [`BLK_SELBITSZ-1:0]    m_sel;
	logic [`BLK_ARCHBITSZ-1:0]   m_rdata;
	logic                        m_rdy;

	case_t cases[$];
	int    errors       = 0;
	int    limit_cycles = 0;

	// power-on reset from the generator or a mid-run reset from the cases
	assign rst = gen_rst | tb_rst;

	tb_clkgen #(
		.PERIOD_NS    (PERIOD_NS),
		.RESET_CYCLES (RESET_CYCLES)
	) u_clkgen (
		.clk_o (clk),
		.rst_o (gen_rst)
	);

	blkdev_boot_sys UUT (
		.clk_i    (clk),
		.rst_i    (rst),
		.m_op_i   (m_op),
		.m_addr_i (m_addr),
		.m_data_i (m_data),
		.m_sel_i  (m_sel),
		.m_data_o (m_rdata),
		.m_rdy_o  (m_rdy)
	);

	// word w of block b after a fill
	function automatic logic [`BLK_ARCHBITSZ-1:0] store_pattern(input int blk, input int word);
		return {8'(blk), 8'(word)};
	endfunction

	task automatic check_value(input logic [`BLK_ARCHBITSZ-1:0] got,
			input logic [`BLK_ARCHBITSZ-1:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic load_cases();
		int    fd;
		int    n;
		int    fields;
		int    f_kind;
		int    f_op;
		int    f_addr;
		int    f_data;
		int    f_sel;
		int    f_exp;
		int    f_chk;
		string line;
		case_t c;
		fd = $fopen("tb/boot_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file tb/boot_cases.txt");
			$display("Done: errors found");
			$fatal(1, "no case file");
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			// skip empty lines and comment lines
			if (n > 1 && line[0] != "#") begin
				fields = $sscanf(line, "%h %h %h %h %h %h %h",
					f_kind, f_op, f_addr, f_data, f_sel, f_exp, f_chk);
				if (fields != 7) begin
					$display("malformed case line: %s", line);
					$display("Done: errors found");
					$fatal(1, "bad case file");
				end
				c.kind    = f_kind;
				c.op      = pi_op_e'(f_op[1:0]);
				c.addr    = f_addr[`BLK_ADDRBITSZ-1:0];
				c.data    = f_data[`BLK_ARCHBITSZ-1:0];
				c.sel     = f_sel[`BLK_SELBITSZ-1:0];
				c.exp_val = f_exp[`BLK_ARCHBITSZ-1:0];
				c.chk     = f_chk[0];
				cases.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	// one master request held until ready and started on a falling edge
	task automatic bus_access(input pi_op_e op, input logic [`BLK_ADDRBITSZ-1:0] addr,
			input logic [`BLK_ARCHBITSZ-1:0] data, input logic [`BLK_SELBITSZ-1:0] sel,
			input logic during_boot, output logic [`BLK_ARCHBITSZ-1:0] rdata,
			output int waited);
		m_op   = op;
		m_addr = addr;
		m_data = data;
		m_sel  = sel;
		waited = 0;
		#(SETTLE_NS);
		while (!m_rdy) begin
			// loader keeps master data at zero until boot ends
			if (during_boot) begin
				check_value(m_rdata, '0, "master data before end of boot");
			end
			@(negedge clk);
			#(SETTLE_NS);
			waited++;
		end
		rdata = m_rdata;
		// transfer completes on the rising edge in between
		@(negedge clk);
		m_op = PI_NOOP;
	endtask

	task automatic run_case(input case_t c, input int idx);
		logic [`BLK_ARCHBITSZ-1:0] rd;
		int                        waited;
		int                        busy_reads;
		case (c.kind)
			K_ACCESS: begin
				bus_access(c.op, c.addr, c.data, c.sel, 1'b0, rd, waited);
				if (c.chk) begin
					check_value(rd, c.exp_val, $sformatf("case %0d, read at %h", idx, c.addr));
				end
			end
			K_POLL: begin
				// repeat the status read until it shows ready
				busy_reads = 0;
				bus_access(c.op, c.addr, c.data, c.sel, 1'b0, rd, waited);
				while (rd != c.exp_val) begin
					check_value(rd, `BLK_ARCHBITSZ'(STATUS_BUSY),
						$sformatf("case %0d, status while polling", idx));
					busy_reads++;
					bus_access(c.op, c.addr, c.data, c.sel, 1'b0, rd, waited);
				end
				// a block transfer keeps status busy for one cycle per word
				if (c.chk) begin
					check_value(`BLK_ARCHBITSZ'(busy_reads), `BLK_ARCHBITSZ'(`BLK_WORDS),
						$sformatf("case %0d, busy status reads", idx));
				end
			end
			K_BOOT: begin
				bus_access(c.op, c.addr, c.data, c.sel, 1'b1, rd, waited);
				check_value(rd, c.exp_val, $sformatf("case %0d, first read after boot", idx));
				check_value(`BLK_ARCHBITSZ'(waited >= FILL_CYCLES), 1,
					$sformatf("case %0d, boot ended before the store fill", idx));
			end
			K_RESET: begin
				tb_rst = 1'b1;
				repeat (RESET_CYCLES) @(negedge clk);
				tb_rst = 1'b0;
			end
			K_BLOCK: begin
				// whole front bank against the fill pattern of one block
				for (int w = 0; w < `BLK_WORDS; w++) begin
					bus_access(c.op, c.addr + `BLK_ADDRBITSZ'(w), c.data, c.sel, 1'b0, rd, waited);
					check_value(rd, store_pattern(int'(c.data), w),
						$sformatf("case %0d, block %0d word %0d", idx, c.data, w));
				end
			end
			default: begin
				$display("case %0d has an unknown kind %0d", idx, c.kind);
				$display("Done: errors found");
				$fatal(1, "bad case kind");
			end
		endcase
	endtask

	initial begin : main
		int boots;
		m_op   = PI_NOOP;
		m_addr = '0;
		m_data = '0;
		m_sel  = '0;
		tb_rst = 1'b0;
		load_cases();
		// every boot costs a full store fill
		boots = 0;
		foreach (cases[i]) begin
			if (cases[i].kind == K_BOOT) begin
				boots++;
			end
		end
		limit_cycles = RESET_CYCLES + boots * (FILL_CYCLES + BOOT_CYCLES)
			+ cases.size() * CASE_CYCLES;
		// first falling edge after the power-on reset is released
		wait (rst === 1'b0);
		@(negedge clk);
		foreach (cases[i]) begin
			run_case(cases[i], i);
		end
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin : watchdog
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout, the cases did not finish within %0d cycles", limit_cycles);
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: blkdev_boot_sys.f
+incdir+design
design/blkdev_pkg.sv
design/boot_loader.sv
design/blkdev_ctrl.sv
design/blkdev_cache.sv
design/blk_store.sv
design/blkdev_boot_sys.sv
tb/tb_clkgen.sv
tb/blkdev_boot_sys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the boot subsystem testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
top=blkdev_boot_sys_tb

verilator --binary --timing --assert -Wno-fatal \
	-f blkdev_boot_sys.f \
	--top-module "$top" \
	--Mdir "$build_dir" \
	-o sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$("./$build_dir/sim" 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Done: no errors" <<< "$output"; then
	exit 0
fi
echo "pass line missing from simulation output"
exit 1

// File: tb/boot_cases.txt
# columns in hex: kind op addr data sel expect check, text after them is a note
# kind 0 access, 1 poll status, 2 read held through boot, 3 reset, 4 front bank vs block
2 2 0013 0000 3 0003 1  read held from reset, block 0 word 3
4 2 0010 0000 3 0000 0  boot block in the front bank
0 3 0000 0000 3 0001 1  status ready
0 3 0002 0005 3 0000 0  read block 5 into the back bank
1 3 0000 0000 3 0001 1  poll, busy for one block
0 3 0001 0000 3 0000 0  swap
4 2 0010 0005 3 0000 0  front bank holds block 5
0 1 0012 1155 1 0000 0  low byte of word 2
0 1 0017 ab00 2 0000 0  high byte of word 7
0 1 0019 beef 3 0000 0  full word 9
0 2 0012 0000 3 0555 1
0 2 0017 0000 3 ab07 1
0 2 0019 0000 3 beef 1
0 3 0001 0000 3 0000 0  swap, written words go to the back
0 3 0003 0003 3 0000 0  write back bank to block 3
1 3 0000 0000 3 0001 1
0 3 0002 0003 3 0000 0  read block 3 back
1 3 0000 0000 3 0001 1
0 3 0001 0000 3 0000 0  swap
0 2 0012 0000 3 0555 1
0 2 0017 0000 3 ab07 1
0 2 0019 0000 3 beef 1
0 2 0010 0000 3 0500 1  untouched word keeps block 5
3 0 0000 0000 0 0000 0  reset mid-run
2 2 0015 0000 3 0005 1  reboot, block 0 word 5
4 2 0010 0000 3 0000 0
0 3 0002 0003 3 0000 0  read block 3 after the refill
1 3 0000 0000 3 0001 1
0 3 0001 0000 3 0000 0
4 2 0010 0003 3 0000 0  block 3 back to its pattern
